// File: rtl/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath sizes
`define CPU_XLEN        32
`define CPU_NUM_REGS    32
`define CPU_REG_ADDR_W  5

// Register-register group, instr[31:15]
`define OPC_ADD_W   17'h00020
`define OPC_SUB_W   17'h00022
`define OPC_SLT     17'h00024
`define OPC_AND     17'h00029
`define OPC_OR      17'h0002a
`define OPC_XOR     17'h0002b

`define OPC_ADDI_W  10'h00a   // instr[31:22]
`define OPC_LU12I_W 7'h0a     // instr[31:25]

// ALU operations
`define ALU_ADD 3'd0
`define ALU_SUB 3'd1
`define ALU_SLT 3'd2
`define ALU_AND 3'd3
`define ALU_OR  3'd4
`define ALU_XOR 3'd5
`define ALU_LUI 3'd6    // Pass src_b through

`endif

// File: rtl/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

    // Data word as held in the register file
    typedef logic [`CPU_XLEN-1:0] word_t;

    // Program counter
    typedef logic [`CPU_XLEN-1:0] addr_t;

    // Raw instruction word
    typedef logic [31:0] instr_t;

    // General register index
    typedef logic [`CPU_REG_ADDR_W-1:0] reg_idx_t;

    // ALU operation select, see ALU_* codes
    typedef logic [2:0] alu_op_t;

endpackage

// File: rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic                clk,
    input  logic                reset_i,

    // Instruction in
    input  logic                instr_valid_i,
    input  cpu_pkg::instr_t     instr_i,
    input  cpu_pkg::addr_t      pc_i,

    // Retire report
    output logic                debug_wb_valid_o,
    output cpu_pkg::addr_t      debug_wb_pc_o,
    output logic                debug_wb_rf_wen_o,
    output cpu_pkg::reg_idx_t   debug_wb_rf_wnum_o,
    output cpu_pkg::word_t      debug_wb_rf_wdata_o
);

    decode_exec_if dec_ex ();
    exec_result_if ex_res ();
    bypass_if      ex_byp ();   // From ALU output
    bypass_if      wb_byp ();   // From execute register
    rf_read_if     rf_rd ();

    decode_stage u_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rf_rd         (rf_rd),
        .ex_byp        (ex_byp),
        .wb_byp        (wb_byp),
        .dec_o         (dec_ex)
    );

    execute_stage u_execute (
        .clk     (clk),
        .reset_i (reset_i),
        .dec_i   (dec_ex),
        .ex_byp  (ex_byp),
        .ex_o    (ex_res)
    );

    result_stage u_result (
        .clk                 (clk),
        .reset_i             (reset_i),
        .ex_i                (ex_res),
        .rf_rd               (rf_rd),
        .wb_byp              (wb_byp),
        .debug_wb_valid_o    (debug_wb_valid_o),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 instr_valid_i,
    input  cpu_pkg::instr_t      instr_i,
    input  cpu_pkg::addr_t       pc_i,
    rf_read_if.requester         rf_rd,
    bypass_if.sink               ex_byp,
    bypass_if.sink               wb_byp,
    decode_exec_if.source        dec_o
);
    import cpu_pkg::*;

    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;
    alu_op_t  alu_op;
    logic     matched;
    logic     use_imm;
    word_t    imm;
    logic     ex_hit_a;
    logic     ex_hit_b;
    logic     wb_hit_a;
    logic     wb_hit_b;
    word_t    opnd_a;
    word_t    opnd_b;

    function automatic logic byp_hit(input logic valid, input logic wen,
                                     input reg_idx_t byp_rd, input reg_idx_t idx);
        return valid && wen && (byp_rd == idx);
    endfunction

    // Youngest producer wins
    function automatic word_t pick_operand(input logic ex_hit, input logic wb_hit,
                                           input word_t ex_data, input word_t wb_data,
                                           input word_t rf_data);
        if (ex_hit)
            return ex_data;
        else if (wb_hit)
            return wb_data;
        return rf_data;
    endfunction

    assign rd = instr_i[4:0];
    assign rj = instr_i[9:5];
    assign rk = instr_i[14:10];

    assign rf_rd.raddr_a = rj;
    assign rf_rd.raddr_b = rk;

    always_comb begin
        alu_op  = `ALU_ADD;
        matched = 1'b1;
        use_imm = 1'b0;
        imm     = '0;
        if (instr_i[31:22] == `OPC_ADDI_W) begin
            use_imm = 1'b1;
            imm     = {{(`CPU_XLEN-12){instr_i[21]}}, instr_i[21:10]}; // si12
        end else if (instr_i[31:25] == `OPC_LU12I_W) begin
            alu_op  = `ALU_LUI;
            use_imm = 1'b1;
            imm     = {instr_i[24:5], 12'b0};
        end else begin
            case (instr_i[31:15])
                `OPC_ADD_W: alu_op = `ALU_ADD;
                `OPC_SUB_W: alu_op = `ALU_SUB;
                `OPC_SLT:   alu_op = `ALU_SLT;
                `OPC_AND:   alu_op = `ALU_AND;
                `OPC_OR:    alu_op = `ALU_OR;
                `OPC_XOR:   alu_op = `ALU_XOR;
                default:    matched = 1'b0;  // Retires as a no-op
            endcase
        end
    end

    assign ex_hit_a = byp_hit(ex_byp.valid, ex_byp.wen, ex_byp.rd, rj);
    assign ex_hit_b = byp_hit(ex_byp.valid, ex_byp.wen, ex_byp.rd, rk);
    assign wb_hit_a = byp_hit(wb_byp.valid, wb_byp.wen, wb_byp.rd, rj);
    assign wb_hit_b = byp_hit(wb_byp.valid, wb_byp.wen, wb_byp.rd, rk);

    assign opnd_a = pick_operand(ex_hit_a, wb_hit_a, ex_byp.data, wb_byp.data, rf_rd.rdata_a);
    assign opnd_b = pick_operand(ex_hit_b, wb_hit_b, ex_byp.data, wb_byp.data, rf_rd.rdata_b);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_o.valid <= 1'b0;
            dec_o.wen   <= 1'b0;
        end else begin
            dec_o.valid <= instr_valid_i;
            dec_o.wen   <= instr_valid_i && matched && (rd != '0); // r0 never written
        end
    end

    always_ff @(posedge clk) begin
        dec_o.alu_op <= alu_op;
        dec_o.rd     <= rd;
        dec_o.src_a  <= opnd_a;
        dec_o.src_b  <= use_imm ? imm : opnd_b;
        dec_o.pc     <= pc_i;
    end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module execute_stage (
    input  logic             clk,
    input  logic             reset_i,
    decode_exec_if.sink      dec_i,
    bypass_if.source         ex_byp,
    exec_result_if.source    ex_o
);
    import cpu_pkg::*;

    word_t alu_res;
    logic  slt_bit;

    assign slt_bit = $signed(dec_i.src_a) < $signed(dec_i.src_b);

    always_comb begin
        case (dec_i.alu_op)
            `ALU_ADD: alu_res = dec_i.src_a + dec_i.src_b;
            `ALU_SUB: alu_res = dec_i.src_a - dec_i.src_b;
            `ALU_SLT: alu_res = {{(`CPU_XLEN-1){1'b0}}, slt_bit};
            `ALU_AND: alu_res = dec_i.src_a & dec_i.src_b;
            `ALU_OR:  alu_res = dec_i.src_a | dec_i.src_b;
            `ALU_XOR: alu_res = dec_i.src_a ^ dec_i.src_b;
            `ALU_LUI: alu_res = dec_i.src_b;   // Immediate already shifted
            default:  alu_res = '0;
        endcase
    end

    // Result visible to decode in the same cycle
    assign ex_byp.valid = dec_i.valid;
    assign ex_byp.wen   = dec_i.wen;
    assign ex_byp.rd    = dec_i.rd;
    assign ex_byp.data  = alu_res;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_o.valid <= 1'b0;
            ex_o.wen   <= 1'b0;
        end else begin
            ex_o.valid <= dec_i.valid;
            ex_o.wen   <= dec_i.wen;
        end
    end

    always_ff @(posedge clk) begin
        ex_o.rd   <= dec_i.rd;
        ex_o.data <= alu_res;
        ex_o.pc   <= dec_i.pc;
    end

endmodule

// File: rtl/result_stage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module result_stage (
    input  logic                clk,
    input  logic                reset_i,
    exec_result_if.sink         ex_i,
    rf_read_if.responder        rf_rd,
    bypass_if.source            wb_byp,
    output logic                debug_wb_valid_o,
    output cpu_pkg::addr_t      debug_wb_pc_o,
    output logic                debug_wb_rf_wen_o,
    output cpu_pkg::reg_idx_t   debug_wb_rf_wnum_o,
    output cpu_pkg::word_t      debug_wb_rf_wdata_o
);
    import cpu_pkg::*;

    word_t regs [`CPU_NUM_REGS];
    logic  rf_we;

    assign rf_we = ex_i.valid && ex_i.wen;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (rf_we) begin
            regs[ex_i.rd] <= ex_i.data;
        end
    end

    // r0 is hardwired to zero
    assign rf_rd.rdata_a = (rf_rd.raddr_a == '0) ? '0 : regs[rf_rd.raddr_a];
    assign rf_rd.rdata_b = (rf_rd.raddr_b == '0) ? '0 : regs[rf_rd.raddr_b];

    // Item being written this cycle, not yet readable from regs
    assign wb_byp.valid = ex_i.valid;
    assign wb_byp.wen   = ex_i.wen;
    assign wb_byp.rd    = ex_i.rd;
    assign wb_byp.data  = ex_i.data;

    // Commit report
    always_ff @(posedge clk) begin
        if (reset_i) begin
            debug_wb_valid_o  <= 1'b0;
            debug_wb_rf_wen_o <= 1'b0;
        end else begin
            debug_wb_valid_o  <= ex_i.valid;
            debug_wb_rf_wen_o <= rf_we;
        end
    end

    always_ff @(posedge clk) begin
        debug_wb_pc_o       <= ex_i.pc;
        debug_wb_rf_wnum_o  <= ex_i.rd;
        debug_wb_rf_wdata_o <= ex_i.data;
    end

endmodule

// File: rtl/stage_if.sv
`timescale 1ns/1ps

// Decode register contents, operands already resolved
interface decode_exec_if;
    import cpu_pkg::*;

    logic     valid;
    alu_op_t  alu_op;
    logic     wen;
    reg_idx_t rd;
    word_t    src_a;
    word_t    src_b;
    addr_t    pc;

    modport source (output valid, alu_op, wen, rd, src_a, src_b, pc);
    modport sink   (input  valid, alu_op, wen, rd, src_a, src_b, pc);
endinterface

// Execute register contents
interface exec_result_if;
    import cpu_pkg::*;

    logic     valid;
    logic     wen;
    reg_idx_t rd;
    word_t    data;
    addr_t    pc;

    modport source (output valid, wen, rd, data, pc);
    modport sink   (input  valid, wen, rd, data, pc);
endinterface

// Forwarding path back to decode
interface bypass_if;
    import cpu_pkg::*;

    logic     valid;
    logic     wen;
    reg_idx_t rd;
    word_t    data;

    modport source (output valid, wen, rd, data);
    modport sink   (input  valid, wen, rd, data);
endinterface

// Two combinational register file read ports
interface rf_read_if;
    import cpu_pkg::*;

    reg_idx_t raddr_a;
    reg_idx_t raddr_b;
    word_t    rdata_a;
    word_t    rdata_b;

    modport requester (output raddr_a, raddr_b, input rdata_a, rdata_b);
    modport responder (input raddr_a, raddr_b, output rdata_a, rdata_b);
endinterface

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module cpu_tb -o cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/cpu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -Fxq "Finished with no errors"; then
    exit 0
fi
echo "Simulation reported failures"
exit 1

// File: sim.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/stage_if.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/cpu_top.sv
verification/cpu_tb.sv

// File: verification/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb;
    import cpu_pkg::*;

    localparam int SEED        = 68026;
    localparam int NUM_CYCLES  = 2000;
    localparam int WATCHDOG_NS = (NUM_CYCLES + 100) * 8;

    localparam logic [3:0] K_ADD = 4'd0;
    localparam logic [3:0] K_SUB = 4'd1;
    localparam logic [3:0] K_SLT = 4'd2;
    localparam logic [3:0] K_AND = 4'd3;
    localparam logic [3:0] K_OR  = 4'd4;
    localparam logic [3:0] K_XOR = 4'd5;
    localparam logic [3:0] K_ADDI  = 4'd6;
    localparam logic [3:0] K_LU12I = 4'd7;
    localparam logic [3:0] K_BAD   = 4'd8;   // Word matching no opcode

    typedef struct packed {
        logic [31:0] stamp;   // Cycle count when it must be on the debug port
        logic [3:0]  kind;
        addr_t       pc;
        logic        wen;
        reg_idx_t    wnum;
        word_t       wdata;
    } retire_t;

    logic     clk = 1'b0;
    logic     reset_i;
    logic     instr_valid_i;
    instr_t   instr_i;
    addr_t    pc_i;
    logic     debug_wb_valid_o;
    addr_t    debug_wb_pc_o;
    logic     debug_wb_rf_wen_o;
    reg_idx_t debug_wb_rf_wnum_o;
    word_t    debug_wb_rf_wdata_o;

    word_t       model_regs [32];
    retire_t     exp_q [$];
    retire_t     chk_item;
    logic [31:0] cycle_cnt = '0;
    addr_t       next_pc;
    int          error_count = 0;
    int          check_count = 0;
    int          drain_wait;

    cpu_top DUT (
        .clk                 (clk),
        .reset_i             (reset_i),
        .instr_valid_i       (instr_valid_i),
        .instr_i             (instr_i),
        .pc_i                (pc_i),
        .debug_wb_valid_o    (debug_wb_valid_o),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 32'd1;

    function automatic string kind_name(input logic [3:0] kind);
        case (kind)
            K_ADD:   return "add.w";
            K_SUB:   return "sub.w";
            K_SLT:   return "slt";
            K_AND:   return "and";
            K_OR:    return "or";
            K_XOR:   return "xor";
            K_ADDI:  return "addi.w";
            K_LU12I: return "lu12i.w";
            default: return "unmatched";
        endcase
    endfunction

    // Mostly r0..r7 so neighbours share registers
    function automatic reg_idx_t pick_reg();
        logic [31:0] r;
        r = $urandom;
        if (r[1:0] != 2'b00)
            return {2'b00, r[4:2]};
        return r[9:5];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("FAILED %s: expected %h, actual %h", name, exp_v, act_v);
        error_count++;
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        logic [3:0]  kind;
        reg_idx_t    rd;
        reg_idx_t    rj;
        reg_idx_t    rk;
        logic [11:0] imm12;
        logic [19:0] imm20;
        instr_t      word;
        word_t       a;
        word_t       b;
        word_t       res;
        retire_t     e;
        r = $urandom;
        if ((r % 32'd5) == 32'd0) begin
            instr_valid_i = 1'b0;   // Bubble with a junk payload
            instr_i       = $urandom;
            pc_i          = $urandom;
            return;
        end
        rd = pick_reg();
        rj = pick_reg();
        rk = pick_reg();
        r = $urandom;
        imm12 = r[11:0];
        imm20 = r[31:12];
        r = $urandom;
        kind = (r[3:0] == 4'd0) ? K_BAD : {1'b0, r[6:4]};
        a = model_regs[rj];
        b = model_regs[rk];
        case (kind)
            K_ADD:   word = {`OPC_ADD_W, rk, rj, rd};
            K_SUB:   word = {`OPC_SUB_W, rk, rj, rd};
            K_SLT:   word = {`OPC_SLT, rk, rj, rd};
            K_AND:   word = {`OPC_AND, rk, rj, rd};
            K_OR:    word = {`OPC_OR, rk, rj, rd};
            K_XOR:   word = {`OPC_XOR, rk, rj, rd};
            K_ADDI:  word = {`OPC_ADDI_W, imm12, rj, rd};
            K_LU12I: word = {`OPC_LU12I_W, imm20, rd};
            default: word = $urandom | 32'h8000_0000;   // Bit 31 set matches no opcode
        endcase
        case (kind)
            K_ADD:   res = a + b;
            K_SUB:   res = a - b;
            K_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_AND:   res = a & b;
            K_OR:    res = a | b;
            K_XOR:   res = a ^ b;
            K_ADDI:  res = a + {{20{imm12[11]}}, imm12};
            K_LU12I: res = {imm20, 12'b0};
            default: res = '0;
        endcase
        e.stamp = cycle_cnt + 32'd3;
        e.kind  = kind;
        e.pc    = next_pc;
        e.wen   = (kind != K_BAD) && (rd != 5'd0);
        e.wnum  = rd;
        e.wdata = res;
        if (e.wen)
            model_regs[rd] = res;
        exp_q.push_back(e);
        instr_valid_i = 1'b1;
        instr_i       = word;
        pc_i          = next_pc;
        next_pc       = next_pc + 32'd4;
    endtask

    task automatic check_retire(input retire_t e);
        string name;
        name = kind_name(e.kind);
        check_count++;
        if (e.stamp != cycle_cnt)
            report_mismatch({name, " retire cycle"}, e.stamp, cycle_cnt);
        if (debug_wb_pc_o != e.pc)
            report_mismatch({name, " pc"}, e.pc, debug_wb_pc_o);
        if (debug_wb_rf_wen_o != e.wen)
            report_mismatch({name, " wen"}, {31'b0, e.wen}, {31'b0, debug_wb_rf_wen_o});
        if (e.wen) begin
            if (debug_wb_rf_wnum_o != e.wnum)
                report_mismatch({name, " wnum"}, {27'b0, e.wnum}, {27'b0, debug_wb_rf_wnum_o});
            if (debug_wb_rf_wdata_o != e.wdata)
                report_mismatch({name, " wdata"}, e.wdata, debug_wb_rf_wdata_o);
        end
    endtask

    // Outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (debug_wb_rf_wen_o && !debug_wb_valid_o) begin
            $display("ERROR: write enable high without a valid retire at cycle %0d", cycle_cnt);
            error_count++;
        end
        if (debug_wb_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: unexpected retire of pc %h at cycle %0d",
                         debug_wb_pc_o, cycle_cnt);
                error_count++;
            end else begin
                chk_item = exp_q.pop_front();
                check_retire(chk_item);
            end
        end else if (exp_q.size() != 0 && exp_q[0].stamp <= cycle_cnt) begin
            $display("ERROR: pc %h did not retire at cycle %0d", exp_q[0].pc, cycle_cnt);
            error_count++;
            exp_q.delete(0);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        next_pc       = 32'h1c00_0000;
        void'($urandom(SEED));
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        repeat (5) @(posedge clk);
        #1 reset_i = 1'b0;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge clk);
            #1 drive_cycle();
        end
        @(posedge clk);
        #1 instr_valid_i = 1'b0;
        drain_wait = 0;
        while (exp_q.size() != 0 && drain_wait < 10) begin
            @(posedge clk);
            drain_wait++;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR: %0d instructions never retired", exp_q.size());
            error_count++;
        end
        $display("Retires checked: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule
